/* design/exu_pkg.sv */
`default_nettype none

package exu_pkg;

  localparam int xlen = 64;

  // major opcodes
  localparam logic [6:0] op_alu_r  = 7'b0110011;
  localparam logic [6:0] op_alu_i  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_system = 7'b1110011;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll,
    alu_srl, alu_sra, alu_slt, alu_sltu, alu_sle, alu_sleu
  } alu_op_e;

  // system function in imm[3:0]
  localparam logic [3:0] sys_priv   = 4'd0;
  localparam logic [3:0] sys_csrrw  = 4'd1;
  localparam logic [3:0] sys_csrrs  = 4'd2;
  localparam logic [3:0] sys_csrrc  = 4'd3;
  localparam logic [3:0] sys_csrrwi = 4'd5;
  localparam logic [3:0] sys_csrrsi = 4'd6;
  localparam logic [3:0] sys_csrrci = 4'd7;

  // privileged code in imm[15:4]
  localparam logic [11:0] sys_ecall  = 12'h000;
  localparam logic [11:0] sys_ebreak = 12'h001;
  localparam logic [11:0] sys_mret   = 12'h302;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  typedef struct packed {
    logic [6:0]      opcode;
    alu_op_e         alu_op;
    logic [4:0]      rd;
    logic            rwen;
    logic            ren;
    logic            wen;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] op_j;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rwaddr;
  } exu_req_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic            rwen;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] npc;
    logic            redirect;
    logic            ebreak;
  } exu_res_t;

  // wen low means read
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic            wen;
  } mem_req_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic            done;
  } mem_rsp_t;

endpackage

`default_nettype wire

/* design/exu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
  input  wire logic [exu_pkg::xlen-1:0] a_i,
  input  wire logic [exu_pkg::xlen-1:0] b_i,
  input  wire exu_pkg::alu_op_e         op_i,
  output logic [exu_pkg::xlen-1:0]      res_o
);

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b_i[5:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;
  assign eq    = a_i == b_i;

  always_comb begin
    res_o = '0;
    case (op_i)
      exu_pkg::alu_add:  res_o = a_i + b_i;
      exu_pkg::alu_sub:  res_o = a_i - b_i;
      exu_pkg::alu_and:  res_o = a_i & b_i;
      exu_pkg::alu_or:   res_o = a_i | b_i;
      exu_pkg::alu_xor:  res_o = a_i ^ b_i;
      exu_pkg::alu_sll:  res_o = a_i << shamt;
      exu_pkg::alu_srl:  res_o = a_i >> shamt;
      exu_pkg::alu_sra:  res_o = $signed(a_i) >>> shamt;
      // compares give 0 or 1
      exu_pkg::alu_slt:  res_o = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
      exu_pkg::alu_sltu: res_o = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
      exu_pkg::alu_sle:  res_o = {{(exu_pkg::xlen-1){1'b0}}, lt_s | eq};
      exu_pkg::alu_sleu: res_o = {{(exu_pkg::xlen-1){1'b0}}, lt_u | eq};
      default:           res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/exu_csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_csr_file (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     commit_i,
  input  wire logic                     op_valid_i,
  input  wire logic [11:0]              addr_i,
  input  wire logic [3:0]               func_i,
  input  wire logic [11:0]              code_i,
  input  wire logic [exu_pkg::xlen-1:0] src_i,
  input  wire logic [exu_pkg::xlen-1:0] pc_i,
  output logic [exu_pkg::xlen-1:0]      rdata_o,
  output logic [exu_pkg::xlen-1:0]      mtvec_o,
  output logic [exu_pkg::xlen-1:0]      mepc_o
);

  logic [exu_pkg::xlen-1:0] mstatus_q, mtvec_q, mepc_q, mcause_q;
  logic [exu_pkg::xlen-1:0] new_val;
  logic                     csr_wr;
  logic                     upd;

  assign upd = commit_i && op_valid_i;

  // unknown addresses read as zero
  always_comb begin
    case (addr_i)
      exu_pkg::csr_mstatus: rdata_o = mstatus_q;
      exu_pkg::csr_mtvec:   rdata_o = mtvec_q;
      exu_pkg::csr_mepc:    rdata_o = mepc_q;
      exu_pkg::csr_mcause:  rdata_o = mcause_q;
      default:              rdata_o = '0;
    endcase
  end

  always_comb begin
    csr_wr  = 1'b1;
    new_val = rdata_o;
    case (func_i)
      exu_pkg::sys_csrrw, exu_pkg::sys_csrrwi: new_val = src_i;
      exu_pkg::sys_csrrs, exu_pkg::sys_csrrsi: new_val = rdata_o | src_i;
      exu_pkg::sys_csrrc, exu_pkg::sys_csrrci: new_val = rdata_o & ~src_i;
      default:                                 csr_wr = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= 64'h100;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (upd) begin
      if (csr_wr) begin
        case (addr_i)
          exu_pkg::csr_mstatus: mstatus_q <= new_val;
          exu_pkg::csr_mtvec:   mtvec_q   <= new_val;
          exu_pkg::csr_mepc:    mepc_q    <= new_val;
          exu_pkg::csr_mcause:  mcause_q  <= new_val;
          default:              ;
        endcase
      end else if (func_i == exu_pkg::sys_priv && code_i == exu_pkg::sys_ecall) begin
        // environment call from m-mode
        mepc_q   <= pc_i;
        mcause_q <= 64'd11;
      end else if (func_i == exu_pkg::sys_priv && code_i == exu_pkg::sys_mret) begin
        mstatus_q[3] <= mstatus_q[7];
        mstatus_q[7] <= 1'b1;
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

`default_nettype wire

/* design/exu_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_branch_unit (
  input  wire logic [6:0]               opcode_i,
  input  wire exu_pkg::alu_op_e         alu_op_i,
  input  wire logic [exu_pkg::xlen-1:0] alu_res_i,
  input  wire logic [exu_pkg::xlen-1:0] target_i,
  input  wire logic [3:0]               func_i,
  input  wire logic [11:0]              code_i,
  input  wire logic [exu_pkg::xlen-1:0] mtvec_i,
  input  wire logic [exu_pkg::xlen-1:0] mepc_i,
  output logic                          redirect_o,
  output logic [exu_pkg::xlen-1:0]      npc_o,
  output logic                          ebreak_o
);

  logic res_nz;

  assign res_nz = |alu_res_i;

  always_comb begin
    redirect_o = 1'b0;
    npc_o      = target_i;
    ebreak_o   = 1'b0;
    case (opcode_i)
      exu_pkg::op_jal, exu_pkg::op_jalr: redirect_o = 1'b1;
      exu_pkg::op_branch: begin
        // beq uses sub, the rest test for a nonzero result
        case (alu_op_i)
          exu_pkg::alu_sub:  redirect_o = !res_nz;
          exu_pkg::alu_xor,
          exu_pkg::alu_slt,
          exu_pkg::alu_sltu,
          exu_pkg::alu_sle,
          exu_pkg::alu_sleu: redirect_o = res_nz;
          default:           redirect_o = 1'b0;
        endcase
      end
      exu_pkg::op_system: begin
        if (func_i == exu_pkg::sys_priv) begin
          case (code_i)
            exu_pkg::sys_ecall: begin
              redirect_o = 1'b1;
              npc_o      = mtvec_i;
            end
            exu_pkg::sys_mret: begin
              redirect_o = 1'b1;
              npc_o      = mepc_i;
            end
            exu_pkg::sys_ebreak: begin
              redirect_o = 1'b1;
              ebreak_o   = 1'b1;
            end
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* design/exu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_core (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              in_valid_i,
  input  wire exu_pkg::exu_req_t in_req_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  output exu_pkg::exu_res_t      out_res_o,
  input  wire logic              out_ready_i,
  output logic                   mem_req_valid_o,
  output exu_pkg::mem_req_t      mem_req_o,
  input  wire exu_pkg::mem_rsp_t mem_rsp_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_mem_wait,
    st_done
  } state_e;

  state_e                   state_q;
  logic                     req_q;
  exu_pkg::exu_req_t        slot_q;
  logic [exu_pkg::xlen-1:0] target_q;
  logic [exu_pkg::xlen-1:0] load_q;

  logic                     accept;
  logic                     commit;
  logic [exu_pkg::xlen-1:0] alu_res;
  logic [exu_pkg::xlen-1:0] csr_rdata;
  logic [exu_pkg::xlen-1:0] mtvec;
  logic [exu_pkg::xlen-1:0] mepc;
  logic                     is_system;

  // req_q marks the cycle a memory request goes out
  assign in_ready_o = (state_q == st_idle && !req_q) || (state_q == st_done && out_ready_i);
  assign accept     = in_valid_i && in_ready_o;
  assign out_valid_o = state_q == st_done;
  assign commit     = out_valid_o && out_ready_i;
  assign is_system  = slot_q.opcode == exu_pkg::op_system;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      req_q   <= 1'b0;
    end else begin
      req_q <= 1'b0;
      case (state_q)
        st_idle:     if (req_q) state_q <= st_mem_wait;
        st_mem_wait: if (mem_rsp_i.done) state_q <= st_done;
        st_done:     if (out_ready_i) state_q <= st_idle;
        default:     state_q <= st_idle;
      endcase
      if (accept) begin
        if (in_req_i.ren || in_req_i.wen) begin
          req_q   <= 1'b1;
          state_q <= st_idle;
        end else begin
          state_q <= st_done;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      slot_q   <= in_req_i;
      target_q <= in_req_i.op_j + in_req_i.imm;
    end
    if (state_q == st_mem_wait && mem_rsp_i.done) begin
      load_q <= mem_rsp_i.rdata;
    end
  end

  assign mem_req_valid_o = req_q;
  assign mem_req_o.addr  = slot_q.rwaddr;
  assign mem_req_o.wdata = slot_q.op2;
  assign mem_req_o.wen   = slot_q.wen;

  exu_alu u_alu (
    .a_i   (slot_q.op1),
    .b_i   (slot_q.op2),
    .op_i  (slot_q.alu_op),
    .res_o (alu_res)
  );

  // csr state moves only when the result is taken
  exu_csr_file u_csr (
    .clk        (clk),
    .rst        (rst),
    .commit_i   (commit),
    .op_valid_i (is_system),
    .addr_i     (slot_q.imm[15:4]),
    .func_i     (slot_q.imm[3:0]),
    .code_i     (slot_q.imm[15:4]),
    .src_i      (slot_q.op1),
    .pc_i       (slot_q.pc),
    .rdata_o    (csr_rdata),
    .mtvec_o    (mtvec),
    .mepc_o     (mepc)
  );

  exu_branch_unit u_branch (
    .opcode_i   (slot_q.opcode),
    .alu_op_i   (slot_q.alu_op),
    .alu_res_i  (alu_res),
    .target_i   (target_q),
    .func_i     (slot_q.imm[3:0]),
    .code_i     (slot_q.imm[15:4]),
    .mtvec_i    (mtvec),
    .mepc_i     (mepc),
    .redirect_o (out_res_o.redirect),
    .npc_o      (out_res_o.npc),
    .ebreak_o   (out_res_o.ebreak)
  );

  assign out_res_o.rd   = slot_q.rd;
  assign out_res_o.rwen = slot_q.rwen;
  assign out_res_o.wdata = (slot_q.opcode == exu_pkg::op_load) ? load_q :
                           is_system ? csr_rdata : alu_res;

  a_res_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> $stable(out_res_o));

  a_no_ren_wen: assert property (@(posedge clk) disable iff (rst)
    in_valid_i |-> !(in_req_i.ren && in_req_i.wen));

  // a response only ever answers the one outstanding request
  a_rsp_in_wait: assert property (@(posedge clk) disable iff (rst)
    mem_rsp_i.done |-> state_q == st_mem_wait);

endmodule

`default_nettype wire

/* design/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
  parameter int mem_depth_log2 = 8,
  parameter int mem_lat        = 2
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              req_valid_i,
  input  wire exu_pkg::mem_req_t req_i,
  output exu_pkg::mem_rsp_t      rsp_o
);

  localparam int cnt_w = $clog2(mem_lat + 1);

  logic [exu_pkg::xlen-1:0] mem [2**mem_depth_log2];
  exu_pkg::mem_req_t        pend_q;
  logic [cnt_w-1:0]         cnt_q;
  logic [mem_depth_log2-1:0] idx;

  // word index above the three byte offset bits
  assign idx = pend_q.addr[mem_depth_log2+2:3];

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (req_valid_i) begin
      cnt_q <= cnt_w'(mem_lat);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      pend_q <= req_i;
    end
    if (rsp_o.done && pend_q.wen) begin
      mem[idx] <= pend_q.wdata;
    end
  end

  // done in the last cycle of the countdown
  assign rsp_o.done  = cnt_q == cnt_w'(1);
  assign rsp_o.rdata = mem[idx];

  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    req_valid_i |-> cnt_q == '0);

endmodule

`default_nettype wire

/* design/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
  parameter int mem_depth_log2 = 8,
  parameter int mem_lat        = 2
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              in_valid_i,
  input  wire exu_pkg::exu_req_t in_req_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  output exu_pkg::exu_res_t      out_res_o,
  input  wire logic              out_ready_i
);

  logic              mem_req_valid;
  exu_pkg::mem_req_t mem_req;
  exu_pkg::mem_rsp_t mem_rsp;

  exu_core u_core (
    .clk             (clk),
    .rst             (rst),
    .in_valid_i      (in_valid_i),
    .in_req_i        (in_req_i),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .out_res_o       (out_res_o),
    .out_ready_i     (out_ready_i),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_rsp_i       (mem_rsp)
  );

  data_mem #(
    .mem_depth_log2 (mem_depth_log2),
    .mem_lat        (mem_lat)
  ) u_mem (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (mem_req_valid),
    .req_i       (mem_req),
    .rsp_o       (mem_rsp)
  );

endmodule

`default_nettype wire

/* verification/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

  localparam int mem_depth_log2 = 6;
  localparam int mem_lat        = 3;
  localparam int mem_words      = 2 ** mem_depth_log2;
  localparam int period         = 40;
  localparam int n_alu          = 40;
  localparam int n_words        = 8;
  localparam int n_mix          = 60;
  // alu, branch, load/store, csr, trap and mixed tests
  localparam int n_req_total    = n_alu + 15 + 2 * n_words + 8 + 7 + n_mix;
  localparam longint watchdog_ns = longint'(n_req_total) * (mem_lat + 4) * period + 100 * period;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              in_valid = 1'b0;
  exu_pkg::exu_req_t in_req = '0;
  logic              in_ready;
  logic              out_valid;
  exu_pkg::exu_res_t out_res;
  logic              out_ready = 1'b1;

  logic [31:0] stim_lfsr = 32'd89267;
  logic [31:0] ready_lfsr = 32'd89267;
  logic        stall_en = 1'b0;

  exu_pkg::exu_req_t exp_q [$];
  exu_pkg::exu_req_t cmp_req;
  exu_pkg::exu_res_t exp_res;
  exu_pkg::exu_res_t held_res;
  logic              held_v = 1'b0;

  int n_acc = 0;
  int n_res = 0;
  int n_checks = 0;
  int n_err = 0;
  int n_tests = 0;
  int err_mark = 0;

  // reference state
  logic [63:0] m_mstatus, m_mtvec, m_mepc, m_mcause;
  logic [63:0] m_mem [mem_words];
  logic [63:0] addr_list [n_words];

  exu_pkg::alu_op_e br_ops [6] = '{exu_pkg::alu_sub, exu_pkg::alu_xor, exu_pkg::alu_slt,
                                   exu_pkg::alu_sltu, exu_pkg::alu_sle, exu_pkg::alu_sleu};
  logic [11:0] csr_addrs [4] = '{exu_pkg::csr_mstatus, exu_pkg::csr_mtvec,
                                 exu_pkg::csr_mepc, exu_pkg::csr_mcause};
  logic [3:0]  csr_funcs [6] = '{exu_pkg::sys_csrrw, exu_pkg::sys_csrrs, exu_pkg::sys_csrrc,
                                 exu_pkg::sys_csrrwi, exu_pkg::sys_csrrsi, exu_pkg::sys_csrrci};
  logic [11:0] priv_codes [3] = '{exu_pkg::sys_ecall, exu_pkg::sys_mret, exu_pkg::sys_ebreak};

  exec_top #(
    .mem_depth_log2 (mem_depth_log2),
    .mem_lat        (mem_lat)
  ) u_exec_top (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid),
    .in_req_i    (in_req),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_res_o   (out_res),
    .out_ready_i (out_ready)
  );

  always #(period / 2) clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      r = {r[62:0], stim_lfsr[0]};
    end
    return r;
  endfunction

  function automatic int rand_below(input int n);
    return int'(rand_bits(8) % 64'(n));
  endfunction

  function automatic logic [63:0] alu_model(input exu_pkg::alu_op_e op,
                                            input logic [63:0] a, input logic [63:0] b);
    logic [5:0] sh;
    sh = b[5:0];
    case (op)
      exu_pkg::alu_add:  return a + b;
      exu_pkg::alu_sub:  return a - b;
      exu_pkg::alu_and:  return a & b;
      exu_pkg::alu_or:   return a | b;
      exu_pkg::alu_xor:  return a ^ b;
      exu_pkg::alu_sll:  return a << sh;
      exu_pkg::alu_srl:  return a >> sh;
      exu_pkg::alu_sra:  return $signed(a) >>> sh;
      exu_pkg::alu_slt:  return {63'h0, $signed(a) < $signed(b)};
      exu_pkg::alu_sltu: return {63'h0, a < b};
      exu_pkg::alu_sle:  return {63'h0, $signed(a) <= $signed(b)};
      exu_pkg::alu_sleu: return {63'h0, a <= b};
      default:           return 64'h0;
    endcase
  endfunction

  function automatic logic [63:0] csr_model_read(input logic [11:0] addr);
    case (addr)
      exu_pkg::csr_mstatus: return m_mstatus;
      exu_pkg::csr_mtvec:   return m_mtvec;
      exu_pkg::csr_mepc:    return m_mepc;
      exu_pkg::csr_mcause:  return m_mcause;
      default:              return 64'h0;
    endcase
  endfunction

  function automatic void csr_model_write(input logic [11:0] addr, input logic [63:0] val);
    case (addr)
      exu_pkg::csr_mstatus: m_mstatus = val;
      exu_pkg::csr_mtvec:   m_mtvec = val;
      exu_pkg::csr_mepc:    m_mepc = val;
      exu_pkg::csr_mcause:  m_mcause = val;
      default: ;
    endcase
  endfunction

  // expected result; updates model state as the result is taken
  function automatic exu_pkg::exu_res_t ref_result(input exu_pkg::exu_req_t r);
    exu_pkg::exu_res_t         res;
    logic [63:0]               alu;
    logic [63:0]               old;
    logic [3:0]                func;
    logic [11:0]               code;
    logic [mem_depth_log2-1:0] idx;
    res = '0;
    func = r.imm[3:0];
    code = r.imm[15:4];
    idx = r.rwaddr[mem_depth_log2+2:3];
    alu = alu_model(r.alu_op, r.op1, r.op2);
    res.rd = r.rd;
    res.rwen = r.rwen;
    res.wdata = alu;
    res.npc = r.op_j + r.imm;
    case (r.opcode)
      exu_pkg::op_load:  res.wdata = m_mem[idx];
      exu_pkg::op_store: m_mem[idx] = r.op2;
      exu_pkg::op_jal, exu_pkg::op_jalr: res.redirect = 1'b1;
      exu_pkg::op_branch: begin
        if (r.alu_op == exu_pkg::alu_sub) begin
          res.redirect = alu == 64'h0;
        end else if (r.alu_op inside {exu_pkg::alu_xor, exu_pkg::alu_slt, exu_pkg::alu_sltu,
                                      exu_pkg::alu_sle, exu_pkg::alu_sleu}) begin
          res.redirect = alu != 64'h0;
        end
      end
      exu_pkg::op_system: begin
        old = csr_model_read(code);
        res.wdata = old;
        case (func)
          exu_pkg::sys_csrrw, exu_pkg::sys_csrrwi: csr_model_write(code, r.op1);
          exu_pkg::sys_csrrs, exu_pkg::sys_csrrsi: csr_model_write(code, old | r.op1);
          exu_pkg::sys_csrrc, exu_pkg::sys_csrrci: csr_model_write(code, old & ~r.op1);
          exu_pkg::sys_priv: begin
            if (code == exu_pkg::sys_ecall) begin
              res.redirect = 1'b1;
              res.npc = m_mtvec;
              m_mepc = r.pc;
              m_mcause = 64'd11;
            end else if (code == exu_pkg::sys_mret) begin
              res.redirect = 1'b1;
              res.npc = m_mepc;
              m_mstatus[3] = m_mstatus[7];
              m_mstatus[7] = 1'b1;
            end else if (code == exu_pkg::sys_ebreak) begin
              res.redirect = 1'b1;
              res.ebreak = 1'b1;
            end
          end
          default: ;
        endcase
      end
      default: ;
    endcase
    return res;
  endfunction

  function automatic exu_pkg::exu_req_t base_req(input logic [6:0] opc,
                                                 input exu_pkg::alu_op_e op);
    exu_pkg::exu_req_t r;
    r = '0;
    r.opcode = opc;
    r.alu_op = op;
    r.rd = 5'(rand_bits(5));
    r.rwen = 1'b1;
    r.op1 = rand_bits(64);
    r.op2 = rand_bits(64);
    r.op_j = rand_bits(64);
    r.imm = rand_bits(64);
    r.pc = rand_bits(64);
    return r;
  endfunction

  function automatic exu_pkg::exu_req_t mem_req(input logic is_load, input logic [63:0] addr,
                                                input logic [63:0] data);
    exu_pkg::exu_req_t r;
    r = base_req(is_load ? exu_pkg::op_load : exu_pkg::op_store, exu_pkg::alu_add);
    r.ren = is_load;
    r.wen = !is_load;
    r.rwaddr = addr;
    r.op2 = data;
    return r;
  endfunction

  // csr address and function travel in imm
  function automatic exu_pkg::exu_req_t csr_req(input logic [11:0] addr, input logic [3:0] func,
                                                input logic [63:0] src);
    exu_pkg::exu_req_t r;
    r = base_req(exu_pkg::op_system, exu_pkg::alu_add);
    r.imm = {48'h0, addr, func};
    r.op1 = src;
    return r;
  endfunction

  function automatic exu_pkg::exu_req_t priv_req(input logic [11:0] code);
    exu_pkg::exu_req_t r;
    r = base_req(exu_pkg::op_system, exu_pkg::alu_add);
    r.imm = {48'h0, code, exu_pkg::sys_priv};
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // called at 2 ns after an edge, returns 2 ns after the accepting edge
  task automatic issue(input exu_pkg::exu_req_t r);
    in_req = r;
    in_valid = 1'b1;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic issue_timed(input exu_pkg::exu_req_t r);
    int cycles;
    cycles = 0;
    issue(r);
    do begin
      @(posedge clk);
      cycles++;
    end while (!out_valid);
    check("latency", 64'(cycles), 64'(mem_lat + 2));
    #2;
  endtask

  task automatic drain();
    while (n_res != n_acc || exp_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic end_test(input string name);
    drain();
    n_tests++;
    if (n_err == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, n_err - err_mark);
    end
    err_mark = n_err;
  endtask

  always @(posedge clk) begin
    #2;
    if (stall_en) begin
      ready_lfsr = lfsr_step(ready_lfsr);
      out_ready = ready_lfsr[0];
    end else begin
      out_ready = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (!rst && in_valid && in_ready) begin
      exp_q.push_back(in_req);
      n_acc++;
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (held_v) begin
        check("out_valid", 64'(out_valid), 64'h1);
        check("out_res.wdata", out_res.wdata, held_res.wdata);
        check("out_res.npc", out_res.npc, held_res.npc);
        check("out_res flags", 64'({out_res.rd, out_res.rwen, out_res.redirect, out_res.ebreak}),
              64'({held_res.rd, held_res.rwen, held_res.redirect, held_res.ebreak}));
      end
      if (out_valid && !out_ready) begin
        check("in_ready", 64'(in_ready), 64'h0);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          n_err++;
          $display("a result was handed out with no request outstanding");
        end else begin
          cmp_req = exp_q.pop_front();
          exp_res = ref_result(cmp_req);
          check("out_res.rd", 64'(out_res.rd), 64'(exp_res.rd));
          check("out_res.rwen", 64'(out_res.rwen), 64'(exp_res.rwen));
          check("out_res.wdata", out_res.wdata, exp_res.wdata);
          check("out_res.npc", out_res.npc, exp_res.npc);
          check("out_res.redirect", 64'(out_res.redirect), 64'(exp_res.redirect));
          check("out_res.ebreak", 64'(out_res.ebreak), 64'(exp_res.ebreak));
        end
        n_res++;
      end
      held_v = out_valid && !out_ready;
      held_res = out_res;
    end
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    exu_pkg::exu_req_t req;
    logic [3:0]        func;
    logic [63:0]       trap_pc;
    int                kind;
    m_mstatus = 64'h0;
    m_mtvec = 64'h100;
    m_mepc = 64'h0;
    m_mcause = 64'h0;
    trap_pc = 64'h8000_0040;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    check("in_ready", 64'(in_ready), 64'h1);
    check("out_valid", 64'(out_valid), 64'h0);

    for (int i = 0; i < n_alu; i++) begin
      issue(base_req(exu_pkg::op_alu_r, exu_pkg::alu_op_e'(4'(rand_below(12)))));
    end
    end_test("alu");

    // equal operands first, then unequal
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 2; k++) begin
        req = base_req(exu_pkg::op_branch, br_ops[i]);
        if (k == 0) begin
          req.op2 = req.op1;
        end
        issue(req);
      end
    end
    issue(base_req(exu_pkg::op_jal, exu_pkg::alu_add));
    issue(base_req(exu_pkg::op_jalr, exu_pkg::alu_add));
    issue(base_req(exu_pkg::op_branch, exu_pkg::alu_add));
    end_test("branch");

    for (int i = 0; i < n_words; i++) begin
      addr_list[i] = rand_bits(mem_depth_log2) << 3;
    end
    for (int i = 0; i < n_words; i++) begin
      issue_timed(mem_req(1'b0, addr_list[i], rand_bits(64)));
    end
    for (int i = 0; i < n_words; i++) begin
      issue_timed(mem_req(1'b1, addr_list[i], 64'h0));
    end
    end_test("load_store");

    issue(csr_req(exu_pkg::csr_mtvec, exu_pkg::sys_csrrw, rand_bits(64)));
    issue(csr_req(exu_pkg::csr_mtvec, exu_pkg::sys_csrrs, rand_bits(64)));
    issue(csr_req(exu_pkg::csr_mtvec, exu_pkg::sys_csrrc, rand_bits(64)));
    issue(csr_req(exu_pkg::csr_mtvec, exu_pkg::sys_csrrs, 64'h0));
    issue(csr_req(exu_pkg::csr_mepc, exu_pkg::sys_csrrwi, rand_bits(5)));
    issue(csr_req(exu_pkg::csr_mepc, exu_pkg::sys_csrrsi, rand_bits(5)));
    issue(csr_req(exu_pkg::csr_mepc, exu_pkg::sys_csrrci, rand_bits(5)));
    issue(csr_req(exu_pkg::csr_mepc, exu_pkg::sys_csrrs, 64'h0));
    end_test("csr");

    // set mpie so that mret moves a one into mie
    issue(csr_req(exu_pkg::csr_mstatus, exu_pkg::sys_csrrs, 64'h80));
    req = priv_req(exu_pkg::sys_ecall);
    req.pc = trap_pc;
    issue(req);
    issue(csr_req(exu_pkg::csr_mepc, exu_pkg::sys_csrrs, 64'h0));
    issue(csr_req(exu_pkg::csr_mcause, exu_pkg::sys_csrrs, 64'h0));
    issue(priv_req(exu_pkg::sys_mret));
    issue(csr_req(exu_pkg::csr_mstatus, exu_pkg::sys_csrrs, 64'h0));
    issue(priv_req(exu_pkg::sys_ebreak));
    end_test("trap");

    @(negedge clk);
    stall_en = 1'b1;
    @(posedge clk);
    #2;
    for (int i = 0; i < n_mix; i++) begin
      kind = rand_below(8);
      case (kind)
        0, 1: req = base_req(exu_pkg::op_alu_r, exu_pkg::alu_op_e'(4'(rand_below(12))));
        2: req = base_req(exu_pkg::op_branch, br_ops[rand_below(6)]);
        3: req = mem_req(1'b0, addr_list[rand_below(n_words)], rand_bits(64));
        4: req = mem_req(1'b1, addr_list[rand_below(n_words)], 64'h0);
        5: begin
          func = csr_funcs[rand_below(6)];
          req = csr_req(csr_addrs[rand_below(4)], func,
                        (func > exu_pkg::sys_csrrc) ? rand_bits(5) : rand_bits(64));
        end
        6: req = priv_req(priv_codes[rand_below(3)]);
        default: req = base_req(rand_bits(1) ? exu_pkg::op_jal : exu_pkg::op_jalr,
                                exu_pkg::alu_add);
      endcase
      issue(req);
    end
    drain();
    @(negedge clk);
    stall_en = 1'b0;
    @(posedge clk);
    #2;
    end_test("stress");

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_err);
    if (n_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
design/exu_pkg.sv
design/exu_alu.sv
design/exu_csr_file.sv
design/exu_branch_unit.sv
design/exu_core.sv
design/data_mem.sv
design/exec_top.sv
verification/exec_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := exec_tb
FILELIST := src.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
